// ==== tilemap_pkg.sv ====
/*
  Shared constants for the scroll layer renderer.
  Register map is word aligned on a 4-bit APB address.
  Tile sizes are one-hot codes, as in the CPS-style control word.
*/
package tilemap_pkg;

    // APB register addresses
    localparam logic [3:0] REG_CTRL = 4'h0;  // size_onehot[2:0], flip[3]
    localparam logic [3:0] REG_HPOS = 4'h4;
    localparam logic [3:0] REG_VPOS = 4'h8;
    localparam logic [3:0] REG_BANK = 4'hc;  // offset[3:0], mask[7:4], limit[31:16]

    localparam logic [2:0] SIZE_8  = 3'b001;
    localparam logic [2:0] SIZE_16 = 3'b010;
    localparam logic [2:0] SIZE_32 = 3'b100;

    typedef enum logic [2:0] {
        TS_8  = SIZE_8,
        TS_16 = SIZE_16,
        TS_32 = SIZE_32
    } tile_size_e;

    localparam int ROM_AW = 20;  // graphics ROM word address

    // line buffer entry is {group, pal, colour}
    localparam int GROUP_W = 2;
    localparam int PAL_W   = 5;
    localparam int COL_W   = 4;
    localparam int ENTRY_W = GROUP_W + PAL_W + COL_W;

    localparam logic [COL_W-1:0] TRANSPARENT = 4'hf;

endpackage

// ==== tilemap_regs.sv ====
/*
  APB register block. pready is tied high, so transfers end in the access cycle.
  A CTRL write with a size that is not one-hot is dropped and flagged on pslverr.
*/
module tilemap_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [2:0]  size_onehot,
    output logic        flip,
    output logic [15:0] hpos,
    output logic [15:0] vpos,
    output logic [3:0]  bank_offset,
    output logic [3:0]  bank_mask,
    output logic [15:0] bank_limit
);
    import tilemap_pkg::*;

    logic access;
    logic addr_ok;
    logic size_ok;
    logic wr_en;

    assign access  = psel && penable;
    assign addr_ok = paddr inside {REG_CTRL, REG_HPOS, REG_VPOS, REG_BANK};
    assign size_ok = pwdata[2:0] inside {SIZE_8, SIZE_16, SIZE_32};
    assign pslverr = access && (!addr_ok || (pwrite && paddr == REG_CTRL && !size_ok));
    assign wr_en   = access && pwrite && !pslverr;
    assign pready  = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            size_onehot <= SIZE_8;
            flip        <= 1'b0;
            hpos        <= 16'd0;
            vpos        <= 16'd0;
            bank_offset <= 4'd0;
            bank_mask   <= 4'hf;     // whole ROM visible
            bank_limit  <= 16'hffff; // nothing unmapped
        end else if (wr_en) begin
            case (paddr)
                REG_CTRL: begin
                    size_onehot <= pwdata[2:0];
                    flip        <= pwdata[3];
                end
                REG_HPOS: hpos <= pwdata[15:0];
                REG_VPOS: vpos <= pwdata[15:0];
                default: begin // REG_BANK
                    bank_offset <= pwdata[3:0];
                    bank_mask   <= pwdata[7:4];
                    bank_limit  <= pwdata[31:16];
                end
            endcase
        end
    end

    always_comb begin
        case (paddr)
            REG_CTRL: prdata = {28'd0, flip, size_onehot};
            REG_HPOS: prdata = {16'd0, hpos};
            REG_VPOS: prdata = {16'd0, vpos};
            REG_BANK: prdata = {bank_limit, 8'd0, bank_mask, bank_offset};
            default:  prdata = 32'd0;
        endcase
    end

    // the decode stage relies on a legal size code from here on
    a_size_onehot: assert property (@(posedge clk) disable iff (rst)
        (access && pwrite && paddr == REG_CTRL) |=> $onehot(size_onehot));

endmodule

// ==== tile_decode.sv ====
/*
  Decode stage. Walks tile columns from hpos, reads code and attribute words
  and forms banked ROM word addresses. LINE_PIXELS must be a multiple of 32:
  the last tile then keeps exactly tile_skip leading pixels, flagged by line_end.
*/
module tile_decode #(
    parameter int LINE_PIXELS = 448
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           stop,
    input  logic [8:0]                     vrender,
    input  logic [2:0]                     size_onehot,
    input  logic                           flip,
    input  logic [15:0]                    hpos,
    input  logic [15:0]                    vpos,
    input  logic [3:0]                     bank_offset,
    input  logic [3:0]                     bank_mask,
    input  logic [15:0]                    bank_limit,
    output logic [7:0]                     tile_addr,
    input  logic [15:0]                    tile_data,
    output logic                           tile_valid,
    input  logic                           tile_ready,
    output logic [tilemap_pkg::ROM_AW-1:0] tile_rom_addr,
    output logic [2:0]                     tile_words,
    output logic                           tile_hflip,
    output logic                           tile_unmapped,
    output logic [1:0]                     tile_group,
    output logic [4:0]                     tile_pal,
    output logic [4:0]                     tile_skip,
    output logic                           line_end
);
    import tilemap_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_CODE, S_ATTR, S_FORM, S_HOLD} state_e;

    state_e      st;
    tile_size_e  sz;
    logic [15:0] vn;
    logic [6:0]  col;
    logic [4:0]  skip;
    logic [9:0]  pix_left;   // scroll pixels still to cover, skipped ones included
    logic        first;
    logic [15:0] code;

    logic [6:0]  col0;
    logic [4:0]  skip0;
    logic [4:0]  row;
    logic [22:0] pre_addr;   // code, row, word index before truncation
    logic [ROM_AW-1:0] rom_word;
    logic [2:0]  words;
    logic [9:0]  tsize;
    logic        last_tile;

    // first column and fine scroll from the live registers
    always_comb begin
        case (tile_size_e'(size_onehot))
            TS_16: begin
                col0  = hpos[10:4];
                skip0 = {1'b0, hpos[3:0]};
            end
            TS_32: begin
                col0  = hpos[11:5];
                skip0 = hpos[4:0];
            end
            default: begin
                col0  = hpos[9:3];
                skip0 = {2'b0, hpos[2:0]};
            end
        endcase
    end

    // attribute word is on tile_data while in S_FORM
    always_comb begin
        row = vn[4:0] ^ {5{tile_data[6]}};
        case (sz)
            TS_16: begin
                pre_addr = {2'b0, code, row[3:0], 1'b0};
                words    = 3'd2;
            end
            TS_32: begin
                pre_addr = {code, row, 2'b0};
                words    = 3'd4;
            end
            default: begin
                pre_addr = {4'b0, code, row[2:0]};
                words    = 3'd1;
            end
        endcase
        rom_word  = {(pre_addr[19:16] & bank_mask) | bank_offset, pre_addr[15:0]};
        tsize     = {4'd0, words, 3'b000};
        last_tile = pix_left <= tsize;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= S_IDLE;
            tile_valid <= 1'b0;
            tile_addr  <= 8'd0;
            col        <= 7'd0;
            pix_left   <= 10'd0;
            first      <= 1'b0;
            line_end   <= 1'b0;
        end else if (stop) begin
            st         <= S_IDLE;
            tile_valid <= 1'b0;
        end else if (start) begin
            st         <= S_CODE;
            tile_valid <= 1'b0;
            col        <= col0;
            tile_addr  <= {col0, 1'b0};  // code word first
            pix_left   <= 10'(LINE_PIXELS) + {5'd0, skip0};
            first      <= 1'b1;
        end else begin
            case (st)
                S_CODE: begin
                    tile_addr[0] <= 1'b1;
                    st           <= S_ATTR;
                end
                S_ATTR: st <= S_FORM;
                S_FORM: begin
                    line_end   <= last_tile;
                    pix_left   <= pix_left - tsize;
                    tile_valid <= 1'b1;
                    st         <= S_HOLD;
                end
                S_HOLD: if (tile_ready) begin
                    tile_valid <= 1'b0;
                    first      <= 1'b0;
                    if (line_end) begin
                        st <= S_IDLE;
                    end else begin
                        col       <= col + 7'd1;      // wraps mod 128
                        tile_addr <= {col + 7'd1, 1'b0};
                        st        <= S_CODE;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sz   <= tile_size_e'(size_onehot);
            vn   <= vpos + {7'd0, vrender ^ {1'b0, {8{flip}}}};
            skip <= skip0;
        end
        if (st == S_ATTR) code <= tile_data;
        if (st == S_FORM) begin
            tile_rom_addr <= rom_word;
            tile_words    <= words;
            tile_hflip    <= tile_data[5];
            tile_unmapped <= code > bank_limit;
            tile_group    <= tile_data[8:7];
            tile_pal      <= tile_data[4:0];
            tile_skip     <= (first || last_tile) ? skip : 5'd0;
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (tile_valid && !tile_ready && !stop && !start) |=> tile_valid &&
        $stable({tile_rom_addr, tile_words, tile_hflip, tile_unmapped,
                 tile_group, tile_pal, tile_skip, line_end}));

endmodule

// ==== pixel_fetch.sv ====
/*
  Execute stage. Fetches the ROM words a tile needs over cs/ok and writes one
  entry per pixel. Words wholly inside the skipped edge are never fetched.
  done is a level, set at the last write or on stop and cleared by start.
*/
module pixel_fetch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic                            stop,
    input  logic                            line_end,
    input  logic                            tile_valid,
    input  logic [tilemap_pkg::ROM_AW-1:0]  tile_rom_addr,
    input  logic [2:0]                      tile_words,
    input  logic                            tile_hflip,
    input  logic                            tile_unmapped,
    input  logic [1:0]                      tile_group,
    input  logic [4:0]                      tile_pal,
    input  logic [4:0]                      tile_skip,
    output logic                            tile_ready,
    output logic [tilemap_pkg::ROM_AW-1:0]  rom_addr,
    output logic                            rom_cs,
    input  logic [31:0]                     rom_data,
    input  logic                            rom_ok,
    output logic                            buf_wr,
    output logic [8:0]                      buf_addr,
    output logic [tilemap_pkg::ENTRY_W-1:0] buf_data,
    output logic                            done
);
    import tilemap_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_WAIT, S_ROM, S_DRAW, S_FIN} state_e;

    state_e      st;
    logic [8:0]  wptr;
    logic [4:0]  p_cur;      // pixel position inside the tile, scan order
    logic [4:0]  p_end;
    logic [4:0]  p_first;
    logic [4:0]  p_next;
    logic        last_t;
    logic        hflip_t;
    logic        unmapped_t;
    logic [1:0]  wmax_t;
    logic [1:0]  group_t;
    logic [4:0]  pal_t;
    logic [ROM_AW-1:0] base_t;
    logic [31:0] pix;

    // hflip walks the words of a row backwards
    function automatic logic [ROM_AW-1:0] word_addr(input logic [ROM_AW-1:0] base,
                                                    input logic [1:0] wmax,
                                                    input logic hf,
                                                    input logic [4:0] p);
        logic [1:0] w;
        w = hf ? wmax - p[4:3] : p[4:3];
        return base | {{(ROM_AW-2){1'b0}}, w};
    endfunction

    function automatic logic [COL_W-1:0] pick(input logic [31:0] d,
                                              input logic hf,
                                              input logic [2:0] i);
        if (hf)
            return {d[24+i], d[16+i], d[8+i], d[i]};
        return {d[31-i], d[23-i], d[15-i], d[7-i]};
    endfunction

    assign tile_ready = (st == S_WAIT);
    assign p_first    = line_end ? 5'd0 : tile_skip; // last tile keeps its lead
    assign p_next     = p_cur + 5'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st     <= S_IDLE;
            rom_cs <= 1'b0;
            buf_wr <= 1'b0;
            done   <= 1'b0;
            wptr   <= 9'd0;
            p_cur  <= 5'd0;
        end else if (stop) begin
            st     <= S_IDLE;
            rom_cs <= 1'b0;
            buf_wr <= 1'b0;
            done   <= 1'b1;
        end else if (start) begin
            st     <= S_WAIT;
            rom_cs <= 1'b0;
            buf_wr <= 1'b0;
            done   <= 1'b0;
            wptr   <= 9'd0;
        end else begin
            buf_wr <= 1'b0;
            case (st)
                S_WAIT: if (tile_valid) begin
                    p_cur  <= p_first;
                    rom_cs <= !tile_unmapped;  // unmapped tiles skip the ROM
                    st     <= tile_unmapped ? S_DRAW : S_ROM;
                end
                S_ROM: if (rom_ok) begin
                    rom_cs <= 1'b0;
                    st     <= S_DRAW;
                end
                S_DRAW: begin
                    buf_wr <= 1'b1;
                    wptr   <= wptr + 9'd1;
                    p_cur  <= p_next;
                    if (p_cur == p_end) begin
                        st <= last_t ? S_FIN : S_WAIT;
                    end else if (p_cur[2:0] == 3'd7 && !unmapped_t) begin
                        rom_cs <= 1'b1;
                        st     <= S_ROM;
                    end
                end
                S_FIN: begin
                    done <= 1'b1;  // last entry lands on this edge
                    st   <= S_IDLE;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            S_WAIT: if (tile_valid) begin
                base_t     <= tile_rom_addr;
                wmax_t     <= tile_words[1:0] - 2'd1;  // 1,2,4 words give 0,1,3
                hflip_t    <= tile_hflip;
                unmapped_t <= tile_unmapped;
                group_t    <= tile_group;
                pal_t      <= tile_pal;
                last_t     <= line_end;
                p_end      <= (line_end && tile_skip != 5'd0) ? tile_skip - 5'd1
                                                              : {tile_words[1:0], 3'b000} - 5'd1;
                rom_addr   <= word_addr(tile_rom_addr, tile_words[1:0] - 2'd1,
                                        tile_hflip, p_first);
            end
            S_ROM: if (rom_ok) pix <= rom_data;
            S_DRAW: begin
                buf_addr <= wptr;
                buf_data <= {group_t, pal_t,
                             unmapped_t ? TRANSPARENT : pick(pix, hflip_t, p_cur[2:0])};
                if (p_cur[2:0] == 3'd7)
                    rom_addr <= word_addr(base_t, wmax_t, hflip_t, p_next);
            end
            default: ;
        endcase
    end

    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok && !stop && !start) |=> rom_cs && $stable(rom_addr));

endmodule

// ==== line_buffer.sv ====
/*
  Line buffer of LINE_PIXELS entries. rd_data is valid one cycle after rd_addr.
  Reads past LINE_PIXELS-1 return undefined data.
*/
module line_buffer #(
    parameter int LINE_PIXELS = 448
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            buf_wr,
    input  logic [8:0]                      buf_addr,
    input  logic [tilemap_pkg::ENTRY_W-1:0] buf_data,
    input  logic [8:0]                      rd_addr,
    output logic [tilemap_pkg::ENTRY_W-1:0] rd_data
);
    import tilemap_pkg::*;

    logic [ENTRY_W-1:0] mem [LINE_PIXELS];

    always_ff @(posedge clk) begin
        if (buf_wr)
            mem[buf_addr] <= buf_data;
        rd_data <= mem[rd_addr]; // mixer port
    end

    // execute must trim the last tile to the line width
    a_wr_range: assert property (@(posedge clk) disable iff (rst)
        buf_wr |-> buf_addr < 9'(LINE_PIXELS));

endmodule

// ==== tilemap_top.sv ====
/*
  Scroll layer renderer top. One start pulse renders line vrender into the
  line buffer; done marks the end. Tile RAM answers one cycle after tile_addr.
*/
module tilemap_top #(
    parameter int LINE_PIXELS = 448
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [3:0]                      paddr,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic                            start,
    input  logic                            stop,
    input  logic [8:0]                      vrender,
    output logic                            done,
    output logic [7:0]                      tile_addr,
    input  logic [15:0]                     tile_data,
    output logic [tilemap_pkg::ROM_AW-1:0]  rom_addr,
    output logic                            rom_cs,
    input  logic [31:0]                     rom_data,
    input  logic                            rom_ok,
    input  logic [8:0]                      rd_addr,
    output logic [tilemap_pkg::ENTRY_W-1:0] rd_data
);
    import tilemap_pkg::*;

    logic [2:0]  size_onehot;
    logic        flip;
    logic [15:0] hpos;
    logic [15:0] vpos;
    logic [3:0]  bank_offset;
    logic [3:0]  bank_mask;
    logic [15:0] bank_limit;

    // decode to execute
    logic              tile_valid;
    logic              tile_ready;
    logic [ROM_AW-1:0] tile_rom_addr;
    logic [2:0]        tile_words;
    logic              tile_hflip;
    logic              tile_unmapped;
    logic [1:0]        tile_group;
    logic [4:0]        tile_pal;
    logic [4:0]        tile_skip;
    logic              line_end;

    // execute to result
    logic               buf_wr;
    logic [8:0]         buf_addr;
    logic [ENTRY_W-1:0] buf_data;

    tilemap_regs i_regs (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .size_onehot, .flip, .hpos, .vpos,
        .bank_offset, .bank_mask, .bank_limit
    );

    tile_decode #(.LINE_PIXELS(LINE_PIXELS)) i_decode (
        .clk, .rst, .start, .stop, .vrender,
        .size_onehot, .flip, .hpos, .vpos,
        .bank_offset, .bank_mask, .bank_limit,
        .tile_addr, .tile_data,
        .tile_valid, .tile_ready, .tile_rom_addr, .tile_words, .tile_hflip,
        .tile_unmapped, .tile_group, .tile_pal, .tile_skip, .line_end
    );

    pixel_fetch i_fetch (
        .clk, .rst, .start, .stop, .line_end,
        .tile_valid, .tile_rom_addr, .tile_words, .tile_hflip,
        .tile_unmapped, .tile_group, .tile_pal, .tile_skip, .tile_ready,
        .rom_addr, .rom_cs, .rom_data, .rom_ok,
        .buf_wr, .buf_addr, .buf_data, .done
    );

    line_buffer #(.LINE_PIXELS(LINE_PIXELS)) i_buf (
        .clk, .rst, .buf_wr, .buf_addr, .buf_data, .rd_addr, .rd_data
    );

endmodule

// ==== tb_tilemap.sv ====
/*
  Testbench for tilemap_top. Tile RAM and graphics ROM are behavioural models.
  ROM words are a hash of the word address; rom_ok delay is fixed or random 0..7,
  and a hold flag keeps a request open. Expected lines come from a reference model.
*/
module tb_tilemap;
    timeunit 1ns;
    timeprecision 1ps;
    import tilemap_pkg::*;

    localparam int LINE_PIXELS = 448;
    localparam int WAIT_LIMIT  = 20000;  // cycles allowed per wait loop

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [3:0]        paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              start;
    logic              stop;
    logic [8:0]        vrender;
    logic              done;
    logic [7:0]        tile_addr;
    logic [15:0]       tile_data = 16'd0;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_cs;
    logic [31:0]       rom_data = 32'd0;
    logic              rom_ok = 1'b0;
    logic [8:0]        rd_addr;
    logic [ENTRY_W-1:0] rd_data;

    logic [15:0]        tram [256];
    logic [ENTRY_W-1:0] exp_line [LINE_PIXELS];
    int                 rom_wait = 0;
    logic               rom_rand;
    logic               rom_hold;

    // layer setup as last written for the reference model
    logic [2:0]  cfg_size;
    logic        cfg_flip;
    logic [15:0] cfg_hpos;
    logic [15:0] cfg_vpos;
    logic [3:0]  cfg_offset;
    logic [3:0]  cfg_mask;
    logic [15:0] cfg_limit;

    tilemap_top #(.LINE_PIXELS(LINE_PIXELS)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rom_hash(input logic [ROM_AW-1:0] a);
        return {12'd0, a} * 32'h9e37_79b1;
    endfunction

    always @(posedge clk) tile_data <= tram[tile_addr];  // one cycle read

    // ok after rom_wait extra cycles, then a fresh delay for the next word
    always @(posedge clk) begin
        rom_ok <= 1'b0;
        if (rom_cs && !rom_ok && !rom_hold) begin
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_hash(rom_addr);
                rom_wait <= rom_rand ? int'($urandom_range(7, 0)) : 0;
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
        $display("TB FAILED");
        $fatal(1, "wait expired");
    endtask

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        int n;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;  // access phase
        n = 0;
        @(negedge clk);
        while (pready !== 1'b1) begin
            if (n == WAIT_LIMIT)
                report_timeout("pready in APB access");
            n++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic set_layer(input logic [2:0] size, input logic fl, input logic [15:0] hp,
                             input logic [15:0] vp, input logic [3:0] ofs,
                             input logic [3:0] msk, input logic [15:0] lim);
        logic err;
        cfg_size   = size;
        cfg_flip   = fl;
        cfg_hpos   = hp;
        cfg_vpos   = vp;
        cfg_offset = ofs;
        cfg_mask   = msk;
        cfg_limit  = lim;
        apb_write(REG_CTRL, {28'd0, fl, size}, err);
        compare_value(32'(err), 32'd0, "pslverr on CTRL write");
        apb_write(REG_HPOS, {16'd0, hp}, err);
        compare_value(32'(err), 32'd0, "pslverr on HPOS write");
        apb_write(REG_VPOS, {16'd0, vp}, err);
        compare_value(32'(err), 32'd0, "pslverr on VPOS write");
        apb_write(REG_BANK, {lim, 8'd0, msk, ofs}, err);
        compare_value(32'(err), 32'd0, "pslverr on BANK write");
    endtask

    task automatic fill_tiles(input logic [15:0] attr_mask);
        for (int k = 0; k < 128; k++) begin
            tram[2 * k]     = 16'($urandom);
            tram[2 * k + 1] = 16'($urandom) & attr_mask;
        end
    endtask

    // expected line straight from the tile, row, bank and pixel rules
    task automatic build_expected(input logic [8:0] vr_in);
        int          t;
        int          vn;
        int          sx;
        int          c;
        int          px;
        int          row;
        int          w;
        int          a;
        int          i;
        logic [8:0]  vr;
        logic [15:0] code;
        logic [15:0] attr;
        logic [31:0] d;
        logic [3:0]  colour;
        t  = (cfg_size == SIZE_32) ? 32 : (cfg_size == SIZE_16) ? 16 : 8;
        vr = cfg_flip ? {vr_in[8], ~vr_in[7:0]} : vr_in;
        vn = (int'(cfg_vpos) + int'(vr)) % 65536;
        for (int x = 0; x < LINE_PIXELS; x++) begin
            sx   = (int'(cfg_hpos) + x) % 65536;
            c    = (sx / t) % 128;
            px   = sx % t;
            code = tram[2 * c];
            attr = tram[2 * c + 1];
            row  = vn % t;
            if (attr[6])
                row = row ^ (t - 1);  // vflip
            w = px / 8;
            if (attr[5])
                w = t / 8 - 1 - w;    // hflip takes words in reverse
            a = (int'(code) * (t * t / 8) + row * (t / 8) + w) % (1 << 20);
            a = (((a >> 16) & int'(cfg_mask)) | int'(cfg_offset)) * 65536 + a % 65536;
            d = rom_hash(20'(a));
            i = px % 8;
            if (code > cfg_limit)
                colour = TRANSPARENT;
            else if (attr[5])
                colour = {d[24 + i], d[16 + i], d[8 + i], d[i]};
            else
                colour = {d[31 - i], d[23 - i], d[15 - i], d[7 - i]};
            exp_line[x] = {attr[8:7], attr[4:0], colour};
        end
    endtask

    task automatic render_line(input logic [8:0] vr);
        int n;
        @(posedge clk);
        start   <= 1'b1;
        vrender <= vr;
        @(posedge clk);
        start <= 1'b0;
        n = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (n == WAIT_LIMIT)
                report_timeout("done after start");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic check_line();
        for (int x = 0; x < LINE_PIXELS; x++) begin
            @(posedge clk);
            rd_addr <= 9'(x);
            @(posedge clk);
            @(negedge clk);  // registered read settled
            compare_value(32'(rd_data), 32'(exp_line[x]), $sformatf("pixel %0d", x));
        end
    endtask

    task automatic register_access();
        logic [31:0] rd;
        logic        err;
        apb_write(REG_CTRL, 32'h0000_000a, err);
        apb_write(REG_HPOS, 32'h0000_1234, err);
        apb_write(REG_VPOS, 32'h0000_0abc, err);
        apb_write(REG_BANK, 32'h5a5a_0037, err);
        apb_read(REG_CTRL, rd, err);
        compare_value(rd, 32'h0000_000a, "CTRL readback");
        apb_read(REG_HPOS, rd, err);
        compare_value(rd, 32'h0000_1234, "HPOS readback");
        apb_read(REG_VPOS, rd, err);
        compare_value(rd, 32'h0000_0abc, "VPOS readback");
        apb_read(REG_BANK, rd, err);
        compare_value(rd, 32'h5a5a_0037, "BANK readback");
        compare_value(32'(err), 32'd0, "pslverr on BANK read");
        apb_write(4'h2, 32'h1, err);
        compare_value(32'(err), 32'd1, "pslverr on unknown write");
        apb_read(4'h6, rd, err);
        compare_value(32'(err), 32'd1, "pslverr on unknown read");
        apb_write(REG_CTRL, 32'h0000_0003, err);  // two size bits set
        compare_value(32'(err), 32'd1, "pslverr on bad size");
        apb_read(REG_CTRL, rd, err);
        compare_value(rd, 32'h0000_000a, "CTRL after bad size");
    endtask

    // fine scroll 5 and no flips
    task automatic scroll_8x8();
        set_layer(SIZE_8, 1'b0, 16'h0135, 16'h0040, 4'h0, 4'hf, 16'hffff);
        fill_tiles(16'h019f);
        build_expected(9'd77);
        render_line(9'd77);
        check_line();
    endtask

    task automatic flip_16x16();
        set_layer(SIZE_16, 1'b1, 16'h03a9, 16'h0012, 4'h0, 4'hf, 16'hffff);
        fill_tiles(16'h01ff);  // random hflip and vflip
        build_expected(9'd150);
        render_line(9'd150);
        check_line();
    endtask

    task automatic bank_32x32();
        set_layer(SIZE_32, 1'b0, 16'h0f4b, 16'h0100, 4'h4, 4'h3, 16'h9000);
        fill_tiles(16'h01ff);
        tram[2 * 122] = 16'hffff;  // first column unmapped
        tram[2 * 123] = 16'h0c40;
        build_expected(9'd200);
        render_line(9'd200);
        check_line();
    endtask

    task automatic stop_abort();
        int n;
        set_layer(SIZE_16, 1'b0, 16'h0021, 16'h0008, 4'h0, 4'hf, 16'hffff);
        fill_tiles(16'h01ff);
        @(posedge clk);
        start   <= 1'b1;
        vrender <= 9'd33;
        @(posedge clk);
        start <= 1'b0;
        n = 0;
        @(negedge clk);
        while (rom_cs !== 1'b1) begin
            if (n == WAIT_LIMIT)
                report_timeout("rom_cs before stop");
            n++;
            @(negedge clk);
        end
        repeat (40) @(posedge clk);
        rom_hold <= 1'b1;  // next ROM request stays open
        n = 0;
        @(negedge clk);
        while (!(rom_cs === 1'b1 && rom_ok === 1'b0)) begin
            if (n == WAIT_LIMIT)
                report_timeout("stalled ROM request before stop");
            n++;
            @(negedge clk);
        end
        compare_value(32'(done), 32'd0, "done before stop");
        @(posedge clk);
        stop <= 1'b1;
        @(posedge clk);
        stop <= 1'b0;
        @(negedge clk);
        compare_value(32'(done), 32'd1, "done after stop");
        compare_value(32'(rom_cs), 32'd0, "rom_cs after stop");
        @(posedge clk);
        rom_hold <= 1'b0;
        build_expected(9'd34);
        render_line(9'd34);
        check_line();
    endtask

    initial begin
        void'($urandom(32));
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = 4'd0;
        pwdata   = 32'd0;
        start    = 1'b0;
        stop     = 1'b0;
        vrender  = 9'd0;
        rd_addr  = 9'd0;
        rom_rand = 1'b0;
        rom_hold = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value(32'(done), 32'd0, "done after reset");
        compare_value(32'(rom_cs), 32'd0, "rom_cs after reset");
        compare_value(32'(pready), 32'd1, "pready after reset");

        register_access();
        scroll_8x8();
        flip_16x16();
        bank_32x32();
        rom_rand = 1'b1;  // ROM back-pressure
        flip_16x16();
        rom_rand = 1'b0;
        stop_abort();

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
tilemap_pkg.sv
tilemap_regs.sv
tile_decode.sv
pixel_fetch.sv
line_buffer.sv
tilemap_top.sv
tb_tilemap.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_tilemap -f src.f -o tb_tilemap \
    && ./obj_dir/tb_tilemap | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
